/* design/bitmanip_pkg.sv */
/*
 * Shared definitions for the bit-manipulation execute unit:
 * widths, opcode and function constants, operation enum,
 * instruction word union and the stage structs
 */
`default_nettype none

package bitmanip_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int xlen    = 32;
   localparam int shamt_w = 5;

   typedef logic [xlen-1:0] xlen_t;

   // Major opcodes, only OP and OP-IMM are handled
   localparam logic [6:0] opc_op     = 7'b011_0011;
   localparam logic [6:0] opc_op_imm = 7'b001_0011;

   // Funct7 groups
   localparam logic [6:0] f7_negate    = 7'b010_0000;
   localparam logic [6:0] f7_minmax    = 7'b000_0101;
   localparam logic [6:0] f7_rotate    = 7'b011_0000;
   localparam logic [6:0] f7_shadd     = 7'b001_0000;
   localparam logic [6:0] f7_bclr_bext = 7'b010_0100;
   localparam logic [6:0] f7_binv      = 7'b011_0100;
   localparam logic [6:0] f7_bset      = 7'b001_0100;
   localparam logic [6:0] f7_zext      = 7'b000_0100;

   // Funct12 codes of the unary group
   localparam logic [11:0] f12_clz    = 12'b0110000_00000;
   localparam logic [11:0] f12_ctz    = 12'b0110000_00001;
   localparam logic [11:0] f12_cpop   = 12'b0110000_00010;
   localparam logic [11:0] f12_sext_b = 12'b0110000_00100;
   localparam logic [11:0] f12_sext_h = 12'b0110000_00101;
   localparam logic [11:0] f12_orc_b  = 12'b0010100_00111;
   localparam logic [11:0] f12_rev8   = 12'b0110100_11000;

   ////////////////////////////////////////////////////////////////////////////
   // Operations, register and immediate forms share one code
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [4:0] {
      op_andn, op_orn, op_xnor,
      op_min, op_minu, op_max, op_maxu,
      op_rol, op_ror,
      op_sh1add, op_sh2add, op_sh3add,
      op_bclr, op_bext, op_binv, op_bset,
      op_clz, op_ctz, op_cpop,
      op_orc_b, op_rev8, op_sext_b, op_sext_h, op_zext_h
   } bm_op_e;

   // R-type view, rs2 field doubles as shamt for immediates
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_view_t;

   // Unary view with the full funct12
   typedef struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_view_t;

   typedef union packed {
      r_view_t r_view;
      u_view_t u_view;
   } instr_word_u;

   // Decode to execute
   typedef struct packed {
      logic   valid;
      bm_op_e op;
      xlen_t  operand_a;
      xlen_t  operand_b;
   } bm_issue_t;

   // Execute to top
   typedef struct packed {
      logic  valid;
      xlen_t data;
   } bm_result_t;

endpackage

`default_nettype wire

/* design/bitmanip_decode.sv */
/*
 * First pipeline stage: instruction decode,
 * second operand select and the issue register
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_decode (
   input  logic                      CLK,
   input  logic                      arst_n,
   input  logic                      valid_cmd,
   input  bitmanip_pkg::instr_word_u instr,
   input  bitmanip_pkg::xlen_t       rs1,
   input  bitmanip_pkg::xlen_t       rs2,
   output bitmanip_pkg::bm_issue_t   issue
);

   bitmanip_pkg::bm_op_e op_nxt;
   logic                 known;
   logic                 imm_form;
   bitmanip_pkg::xlen_t  operand_b_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // Opcode and function match
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      op_nxt   = bitmanip_pkg::op_andn;
      known    = 1'b0;
      imm_form = 1'b0;
      if (instr.r_view.opcode == bitmanip_pkg::opc_op) begin
         known = 1'b1;
         case ({instr.r_view.funct7, instr.r_view.funct3})
            {bitmanip_pkg::f7_negate, 3'b111}:    op_nxt = bitmanip_pkg::op_andn;
            {bitmanip_pkg::f7_negate, 3'b110}:    op_nxt = bitmanip_pkg::op_orn;
            {bitmanip_pkg::f7_negate, 3'b100}:    op_nxt = bitmanip_pkg::op_xnor;
            {bitmanip_pkg::f7_minmax, 3'b100}:    op_nxt = bitmanip_pkg::op_min;
            {bitmanip_pkg::f7_minmax, 3'b101}:    op_nxt = bitmanip_pkg::op_minu;
            {bitmanip_pkg::f7_minmax, 3'b110}:    op_nxt = bitmanip_pkg::op_max;
            {bitmanip_pkg::f7_minmax, 3'b111}:    op_nxt = bitmanip_pkg::op_maxu;
            {bitmanip_pkg::f7_rotate, 3'b001}:    op_nxt = bitmanip_pkg::op_rol;
            {bitmanip_pkg::f7_rotate, 3'b101}:    op_nxt = bitmanip_pkg::op_ror;
            {bitmanip_pkg::f7_shadd, 3'b010}:     op_nxt = bitmanip_pkg::op_sh1add;
            {bitmanip_pkg::f7_shadd, 3'b100}:     op_nxt = bitmanip_pkg::op_sh2add;
            {bitmanip_pkg::f7_shadd, 3'b110}:     op_nxt = bitmanip_pkg::op_sh3add;
            {bitmanip_pkg::f7_bclr_bext, 3'b001}: op_nxt = bitmanip_pkg::op_bclr;
            {bitmanip_pkg::f7_bclr_bext, 3'b101}: op_nxt = bitmanip_pkg::op_bext;
            {bitmanip_pkg::f7_binv, 3'b001}:      op_nxt = bitmanip_pkg::op_binv;
            {bitmanip_pkg::f7_bset, 3'b001}:      op_nxt = bitmanip_pkg::op_bset;
            {bitmanip_pkg::f7_zext, 3'b100}: begin
               // zext.h lives in OP with rs2 field fixed at zero
               op_nxt = bitmanip_pkg::op_zext_h;
               known  = (instr.r_view.rs2 == '0);
            end
            default: known = 1'b0;
         endcase
      end else if (instr.u_view.opcode == bitmanip_pkg::opc_op_imm) begin
         known = 1'b1;
         // Unary group first, full funct12 match
         case ({instr.u_view.funct12, instr.u_view.funct3})
            {bitmanip_pkg::f12_clz, 3'b001}:    op_nxt = bitmanip_pkg::op_clz;
            {bitmanip_pkg::f12_ctz, 3'b001}:    op_nxt = bitmanip_pkg::op_ctz;
            {bitmanip_pkg::f12_cpop, 3'b001}:   op_nxt = bitmanip_pkg::op_cpop;
            {bitmanip_pkg::f12_sext_b, 3'b001}: op_nxt = bitmanip_pkg::op_sext_b;
            {bitmanip_pkg::f12_sext_h, 3'b001}: op_nxt = bitmanip_pkg::op_sext_h;
            {bitmanip_pkg::f12_orc_b, 3'b101}:  op_nxt = bitmanip_pkg::op_orc_b;
            {bitmanip_pkg::f12_rev8, 3'b101}:   op_nxt = bitmanip_pkg::op_rev8;
            default: begin
               // Immediate forms, shamt in the rs2 field
               imm_form = 1'b1;
               case ({instr.r_view.funct7, instr.r_view.funct3})
                  {bitmanip_pkg::f7_rotate, 3'b101}:    op_nxt = bitmanip_pkg::op_ror;
                  {bitmanip_pkg::f7_bclr_bext, 3'b001}: op_nxt = bitmanip_pkg::op_bclr;
                  {bitmanip_pkg::f7_bclr_bext, 3'b101}: op_nxt = bitmanip_pkg::op_bext;
                  {bitmanip_pkg::f7_binv, 3'b001}:      op_nxt = bitmanip_pkg::op_binv;
                  {bitmanip_pkg::f7_bset, 3'b001}:      op_nxt = bitmanip_pkg::op_bset;
                  default: known = 1'b0;
               endcase
            end
         endcase
      end
   end

   // Zero-extended shamt for immediates
   assign operand_b_nxt = imm_form ? bitmanip_pkg::xlen_t'(instr.r_view.rs2) : rs2;

   // Issue register, bubble unless strobed and recognised
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         issue <= '0;
      end else begin
         issue.valid     <= valid_cmd && known;
         issue.op        <= op_nxt;
         issue.operand_a <= rs1;
         issue.operand_b <= operand_b_nxt;
      end
   end

endmodule

`default_nettype wire

/* design/bitmanip_count_unit.sv */
/*
 * Combinational leading zero, trailing zero
 * and population count of one word
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_count_unit (
   input  bitmanip_pkg::xlen_t value,
   output bitmanip_pkg::xlen_t lead_zeros,
   output bitmanip_pkg::xlen_t trail_zeros,
   output bitmanip_pkg::xlen_t pop_count
);

   // Scan upward, highest set bit wins
   // Zero input keeps xlen
   always_comb begin
      lead_zeros = bitmanip_pkg::xlen_t'(bitmanip_pkg::xlen);
      for (int i = 0; i < bitmanip_pkg::xlen; i++) begin
         if (value[i]) begin
            lead_zeros = bitmanip_pkg::xlen_t'(bitmanip_pkg::xlen - 1 - i);
         end
      end
   end

   // Scan downward, lowest set bit wins
   always_comb begin
      trail_zeros = bitmanip_pkg::xlen_t'(bitmanip_pkg::xlen);
      for (int i = bitmanip_pkg::xlen - 1; i >= 0; i--) begin
         if (value[i]) begin
            trail_zeros = bitmanip_pkg::xlen_t'(i);
         end
      end
   end

   // Plain adder chain
   always_comb begin
      pop_count = '0;
      for (int i = 0; i < bitmanip_pkg::xlen; i++) begin
         pop_count = pop_count + bitmanip_pkg::xlen_t'(value[i]);
      end
   end

endmodule

`default_nettype wire

/* design/bitmanip_execute.sv */
/*
 * Second pipeline stage: computes the selected
 * operation and registers the result word
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_execute (
   input  logic                     CLK,
   input  logic                     arst_n,
   input  bitmanip_pkg::bm_issue_t  issue,
   output bitmanip_pkg::bm_result_t result
);

   bitmanip_pkg::xlen_t                   op_a;
   bitmanip_pkg::xlen_t                   op_b;
   logic [bitmanip_pkg::shamt_w-1:0]      amt;
   bitmanip_pkg::xlen_t                   bit_mask;
   logic [2*bitmanip_pkg::xlen-1:0]       rol_wide;
   logic [2*bitmanip_pkg::xlen-1:0]       ror_wide;
   logic                                  lt_s;
   logic                                  lt_u;
   bitmanip_pkg::xlen_t                   orc_b;
   bitmanip_pkg::xlen_t                   rev8;
   bitmanip_pkg::xlen_t                   lead_zeros;
   bitmanip_pkg::xlen_t                   trail_zeros;
   bitmanip_pkg::xlen_t                   pop_count;
   bitmanip_pkg::xlen_t                   res_nxt;

   assign op_a = issue.operand_a;
   assign op_b = issue.operand_b;

   // Rotate amount and bit index, low bits only
   assign amt      = op_b[bitmanip_pkg::shamt_w-1:0];
   assign bit_mask = bitmanip_pkg::xlen_t'(1) << amt;

   // Rotates via a doubled word
   assign rol_wide = {op_a, op_a} << amt;
   assign ror_wide = {op_a, op_a} >> amt;

   assign lt_s = $signed(op_a) < $signed(op_b);
   assign lt_u = op_a < op_b;

   bitmanip_count_unit count0 (
      .value       (op_a),
      .lead_zeros  (lead_zeros),
      .trail_zeros (trail_zeros),
      .pop_count   (pop_count)
   );

   // Byte-wise OR-combine and byte reverse
   always_comb begin
      for (int i = 0; i < bitmanip_pkg::xlen / 8; i++) begin
         orc_b[8*i +: 8] = {8{|op_a[8*i +: 8]}};
         rev8[8*i +: 8]  = op_a[bitmanip_pkg::xlen-8-8*i +: 8];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Result select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (issue.op)
         bitmanip_pkg::op_andn:   res_nxt = op_a & ~op_b;
         bitmanip_pkg::op_orn:    res_nxt = op_a | ~op_b;
         bitmanip_pkg::op_xnor:   res_nxt = ~(op_a ^ op_b);
         bitmanip_pkg::op_min:    res_nxt = lt_s ? op_a : op_b;
         bitmanip_pkg::op_minu:   res_nxt = lt_u ? op_a : op_b;
         bitmanip_pkg::op_max:    res_nxt = lt_s ? op_b : op_a;
         bitmanip_pkg::op_maxu:   res_nxt = lt_u ? op_b : op_a;
         bitmanip_pkg::op_rol:    res_nxt = rol_wide[2*bitmanip_pkg::xlen-1:bitmanip_pkg::xlen];
         bitmanip_pkg::op_ror:    res_nxt = ror_wide[bitmanip_pkg::xlen-1:0];
         bitmanip_pkg::op_sh1add: res_nxt = op_b + (op_a << 1);
         bitmanip_pkg::op_sh2add: res_nxt = op_b + (op_a << 2);
         bitmanip_pkg::op_sh3add: res_nxt = op_b + (op_a << 3);
         bitmanip_pkg::op_bclr:   res_nxt = op_a & ~bit_mask;
         // Indexed bit lands in bit 0
         bitmanip_pkg::op_bext:   res_nxt = bitmanip_pkg::xlen_t'(op_a[amt]);
         bitmanip_pkg::op_binv:   res_nxt = op_a ^ bit_mask;
         bitmanip_pkg::op_bset:   res_nxt = op_a | bit_mask;
         bitmanip_pkg::op_clz:    res_nxt = lead_zeros;
         bitmanip_pkg::op_ctz:    res_nxt = trail_zeros;
         bitmanip_pkg::op_cpop:   res_nxt = pop_count;
         bitmanip_pkg::op_orc_b:  res_nxt = orc_b;
         bitmanip_pkg::op_rev8:   res_nxt = rev8;
         bitmanip_pkg::op_sext_b: res_nxt = {{(bitmanip_pkg::xlen-8){op_a[7]}}, op_a[7:0]};
         bitmanip_pkg::op_sext_h: res_nxt = {{(bitmanip_pkg::xlen-16){op_a[15]}}, op_a[15:0]};
         bitmanip_pkg::op_zext_h: res_nxt = {{(bitmanip_pkg::xlen-16){1'b0}}, op_a[15:0]};
         default:                 res_nxt = '0;
      endcase
   end

   // Result register, data forced to zero on a bubble
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else begin
         result.valid <= issue.valid;
         result.data  <= issue.valid ? res_nxt : '0;
      end
   end

endmodule

`default_nettype wire

/* design/bitmanip_top.sv */
/*
 * Top level of the bit-manipulation unit
 * Decode then execute, fixed two-cycle latency
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_top (
   input  logic        CLK,
   input  logic        arst_n,
   input  logic        valid_cmd,
   input  logic [31:0] instr,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic        valid,
   output logic [31:0] bitmanip_out
);

   bitmanip_pkg::bm_issue_t  issue;
   bitmanip_pkg::bm_result_t result;

   // Stage 1
   bitmanip_decode decode0 (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .valid_cmd (valid_cmd),
      .instr     (bitmanip_pkg::instr_word_u'(instr)),
      .rs1       (bitmanip_pkg::xlen_t'(rs1)),
      .rs2       (bitmanip_pkg::xlen_t'(rs2)),
      .issue     (issue)
   );

   // Stage 2
   bitmanip_execute execute0 (
      .CLK    (CLK),
      .arst_n (arst_n),
      .issue  (issue),
      .result (result)
   );

   assign valid        = result.valid;
   assign bitmanip_out = result.data;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * 4 ns clock, reset held low for 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   localparam int reset_cycles = 3;

   // 2 ns half period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/bitmanip_sva.sv */
/*
 * Concurrent checks on the output strobe and data,
 * bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_sva (
   input logic        clk,
   input logic        arst_n,
   input logic        valid_cmd,
   input logic        valid,
   input logic [31:0] bitmanip_out
);

   // Fixed latency, a result needs a strobe two edges back
   property p_valid_from_cmd;
      @(posedge clk) disable iff (!arst_n) valid |-> $past(valid_cmd, 2);
   endproperty

   // Bubbles carry zero data
   property p_idle_zero;
      @(posedge clk) disable iff (!arst_n) !valid |-> (bitmanip_out == '0);
   endproperty

   property p_known_out;
      @(posedge clk) disable iff (!arst_n) !$isunknown({valid, bitmanip_out});
   endproperty

   a_valid_from_cmd: assert property (p_valid_from_cmd)
      else $error("valid seen without a command two cycles earlier");
   a_idle_zero: assert property (p_idle_zero)
      else $error("bitmanip_out nonzero while valid is low");
   a_known_out: assert property (p_known_out)
      else $error("valid or bitmanip_out unknown out of reset");

endmodule

bind bitmanip_top bitmanip_sva sva0 (
   .clk          (CLK),
   .arst_n       (arst_n),
   .valid_cmd    (valid_cmd),
   .valid        (valid),
   .bitmanip_out (bitmanip_out)
);

`default_nettype wire

/* testbench/bitmanip_tb.sv */
/*
 * Testbench for the bit-manipulation unit: loads the vector file,
 * issues one vector per cycle and checks each result two cycles later
 */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_tb;

   localparam int reset_timeout = 20;
   localparam int drain_timeout = 8;

   typedef struct packed {
      logic [31:0]         instr;
      bitmanip_pkg::xlen_t rs1;
      bitmanip_pkg::xlen_t rs2;
   } stim_t;

   logic        clk;
   logic        arst_n;
   logic        valid_cmd;
   logic [31:0] instr;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic        valid;
   logic [31:0] bitmanip_out;

   // Loaded vectors, then the in-flight expectations
   stim_t                    stim_q[$];
   bitmanip_pkg::bm_result_t vec_exp_q[$];
   string                    vec_name_q[$];
   bitmanip_pkg::bm_result_t exp_q[$];
   string                    name_q[$];

   tb_clock_gen clock0 (
      .clk    (clk),
      .arst_n (arst_n)
   );

   bitmanip_top dut0 (
      .CLK          (clk),
      .arst_n       (arst_n),
      .valid_cmd    (valid_cmd),
      .instr        (instr),
      .rs1          (rs1),
      .rs2          (rs2),
      .valid        (valid),
      .bitmanip_out (bitmanip_out)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reporting and compares
   ////////////////////////////////////////////////////////////////////////////
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_valid(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         stop_on_error($sformatf("Fail %s valid expected %0b actual %0b",
                                 name, exp_v, act_v));
      end
   endtask

   task automatic check_data(input string name, input bitmanip_pkg::xlen_t exp_d,
                             input bitmanip_pkg::xlen_t act_d);
      if (act_d !== exp_d) begin
         stop_on_error($sformatf("Fail %s data expected %08h actual %08h",
                                 name, exp_d, act_d));
      end
   endtask

   // Columns: instr rs1 rs2 valid result name, comment lines start with /
   task automatic load_vectors();
      int                       fd;
      int                       n;
      string                    line;
      string                    name;
      logic [31:0]              f_instr;
      logic [31:0]              f_rs1;
      logic [31:0]              f_rs2;
      logic [31:0]              f_valid;
      logic [31:0]              f_data;
      bitmanip_pkg::bm_result_t exp_r;
      fd = $fopen("testbench/bitmanip_testdata.txt", "r");
      if (fd == 0) begin
         stop_on_error("could not open the test data file");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "/") begin
            n = $sscanf(line, "%h %h %h %h %h %s",
                        f_instr, f_rs1, f_rs2, f_valid, f_data, name);
            if (n != 6) begin
               stop_on_error({"malformed test data line: ", line});
            end
            exp_r.valid = f_valid[0];
            exp_r.data  = f_data;
            stim_q.push_back('{instr: f_instr, rs1: f_rs1, rs2: f_rs2});
            vec_exp_q.push_back(exp_r);
            vec_name_q.push_back(name);
         end
      end
      $fclose(fd);
      if (stim_q.size() == 0) begin
         stop_on_error("the test data file holds no vectors");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One falling edge, check the slot issued two edges back then drive
   ////////////////////////////////////////////////////////////////////////////
   task automatic step_cycle(input bit drain);
      bitmanip_pkg::bm_result_t exp_r;
      string                    name;
      stim_t                    s;
      @(negedge clk);
      if (exp_q.size() >= 2 || (drain && exp_q.size() > 0)) begin
         exp_r = exp_q.pop_front();
         name  = name_q.pop_front();
         check_valid(name, exp_r.valid, valid);
         // Data only means something on a valid result
         if (exp_r.valid) begin
            check_data(name, exp_r.data, bitmanip_out);
         end
      end
      if (!drain) begin
         s         = stim_q.pop_front();
         valid_cmd = 1'b1;
         instr     = s.instr;
         rs1       = s.rs1;
         rs2       = s.rs2;
         exp_q.push_back(vec_exp_q.pop_front());
         name_q.push_back(vec_name_q.pop_front());
      end else begin
         valid_cmd = 1'b0;
         instr     = '0;
         rs1       = '0;
         rs2       = '0;
      end
   endtask

   initial begin
      int wait_cycles;
      valid_cmd = 1'b0;
      instr     = '0;
      rs1       = '0;
      rs2       = '0;
      load_vectors();
      wait_cycles = 0;
      while (arst_n !== 1'b1) begin
         @(posedge clk);
         wait_cycles++;
         if (wait_cycles > reset_timeout) begin
            stop_on_error("reset was not released in time");
         end
      end
      // Back to back issue, one vector per cycle
      while (stim_q.size() > 0) begin
         step_cycle(1'b0);
      end
      wait_cycles = 0;
      while (exp_q.size() > 0) begin
         step_cycle(1'b1);
         wait_cycles++;
         if (wait_cycles > drain_timeout) begin
            stop_on_error("results did not drain in time");
         end
      end
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* bitmanip.f */
design/bitmanip_pkg.sv
design/bitmanip_decode.sv
design/bitmanip_count_unit.sv
design/bitmanip_execute.sv
design/bitmanip_top.sv
testbench/tb_clock_gen.sv
testbench/bitmanip_sva.sv
testbench/bitmanip_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the bit-manipulation testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bitmanip_tb \
   -f bitmanip.f -o bitmanip_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build returned status $status"
   exit "$status"
fi

./obj_dir/bitmanip_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation returned status $status"
   exit "$status"
fi

exit 0

/* testbench/bitmanip_testdata.txt */
// instr    rs1      rs2      valid result   name
// all hex, one vector per line, issued back to back
4020F1B3 F0F0F0F0 FF00FF00 1 00F000F0 andn_mix
4020F1B3 FFFFFFFF 00000000 1 FFFFFFFF andn_ones
4020E1B3 12340000 FFFF0000 1 1234FFFF orn_mix
4020C1B3 AAAA5555 FFFF0000 1 AAAAAAAA xnor_mix
0A20C1B3 80000000 00000001 1 80000000 min_sign
0A20D1B3 80000000 00000001 1 00000001 minu_sign
0A20E1B3 80000000 00000001 1 00000001 max_sign
0A20F1B3 80000000 00000001 1 80000000 maxu_sign
602091B3 80000001 00000004 1 00000018 rol_4
602091B3 12345678 FFFFFFE0 1 12345678 rol_hi_bits
6020D1B3 12345678 00000024 1 81234567 ror_4
6080D193 12345678 DEADBEEF 1 78123456 rori_8
2020A1B3 00000010 00000003 1 00000023 sh1add
2020C1B3 40000001 00000100 1 00000104 sh2add_wrap
2020E1B3 00000005 FFFFFFFF 1 00000027 sh3add_neg
482091B3 FFFFFFFF 0000001F 1 7FFFFFFF bclr_31
4820D1B3 00000400 0000000A 1 00000001 bext_set
4820D1B3 00000400 0000002B 1 00000000 bext_clear
682091B3 00000000 00000003 1 00000008 binv_3
282091B3 00000001 00000001 1 00000003 bset_1
48409193 000000FF FFFFFFFF 1 000000EF bclri_4
49F0D193 80000000 00000000 1 00000001 bexti_31
68009193 00000001 00000005 1 00000000 binvi_0
29009193 00000000 00000000 1 00010000 bseti_16
60009193 00000000 00000000 1 00000020 clz_zero
60009193 FFFFFFFF 00000000 1 00000000 clz_ones
60009193 00008000 00000000 1 00000010 clz_bit15
60109193 00000000 00000000 1 00000020 ctz_zero
60109193 00008000 00000000 1 0000000F ctz_bit15
60209193 FFFFFFFF 00000000 1 00000020 cpop_ones
60209193 00010000 00000000 1 00000001 cpop_bit16
2870D193 00100380 00000000 1 00FFFFFF orc_b
6980D193 12345678 00000000 1 78563412 rev8
60409193 00000080 00000000 1 FFFFFF80 sext_b
60509193 12348000 00000000 1 FFFF8000 sext_h
0800C1B3 FFFF1234 00000000 1 00001234 zext_h
6000919B 00000001 00000000 0 00000000 clzw_dropped
0A2091B3 00000003 00000005 0 00000000 clmul_dropped
002081B3 00000003 00000005 0 00000000 add_unknown
